//--- hw/stepper_cfg.svh
`ifndef STEPPER_CFG_SVH
`define STEPPER_CFG_SVH

// motors sharing one speed table
`define STEP_MOTOR_NBR 4

// clock cycles per ring turn, >= motor count and >= 4
`define STEP_SLOT_DIV 8

// table entry width, a step period in slot ticks
`define STEP_SPEED_W 16

`define STEP_ADDR_W 9 // table index width

`define STEP_TAB_DEPTH (1 << `STEP_ADDR_W)

`define STEP_COUNT_W 16 // step count and position

`endif

//--- hw/stepper_pkg.sv
`include "stepper_cfg.svh"

package stepper_pkg;

	// step period, counted in slot ticks
	typedef logic [`STEP_SPEED_W-1:0] speed_t;

	typedef logic [`STEP_ADDR_W-1:0] tab_addr_t;

	// step count or position, wraps
	typedef logic [`STEP_COUNT_W-1:0] step_t;

	// move command, latched on start
	typedef struct packed {
		step_t     steps;
		tab_addr_t limit; // highest ramp index
		logic      dir;   // 1 counts position up
	} motor_cmd_t;

	typedef struct packed {
		logic   busy;
		speed_t rt_speed;
		step_t  position;
	} motor_stat_t;

	typedef enum logic [1:0] {
		idle,
		fetch, // waiting for own slot to read the table
		run,
		last   // timing the final step
	} move_state_e;

endpackage

//--- hw/speed_table.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module speed_table (
	input  logic                                          clk,
	input  logic                                          resetn,
	input  logic                                          tab_load,
	input  logic                                          tab_wr,
	input  stepper_pkg::speed_t                           tab_data,
	input  logic [`STEP_MOTOR_NBR-1:0]                    rd_en,
	input  stepper_pkg::tab_addr_t [`STEP_MOTOR_NBR-1:0]  rd_addr,
	output stepper_pkg::speed_t                           rd_data,
	output stepper_pkg::tab_addr_t                        tab_top
);
	stepper_pkg::speed_t    mem [`STEP_TAB_DEPTH];
	stepper_pkg::tab_addr_t wr_ptr;
	stepper_pkg::tab_addr_t addr_merge;
	stepper_pkg::tab_addr_t addr_q;
	logic                   rd_q;
	logic                   wr_en;

	assign wr_en = tab_load && tab_wr;

	// only the motor in its slot has rd_en set
	always_comb begin
		addr_merge = '0;
		for (int i = 0; i < `STEP_MOTOR_NBR; i++) begin
			addr_merge |= rd_en[i] ? rd_addr[i] : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= |rd_en;
		end
	end

	always_ff @(posedge clk) begin
		addr_q <= addr_merge;
	end

	// load pointer and table top
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			tab_top <= '0;
		end else if (!tab_load) begin
			wr_ptr <= '0; // top is kept
		end else if (tab_wr) begin
			wr_ptr <= wr_ptr + 1'b1;
			tab_top <= wr_ptr;
		end
	end

	// single port, write wins
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= tab_data;
		end else if (rd_q) begin
			rd_data <= mem[addr_q]; // held until next read
		end
	end

endmodule

//--- hw/move_ctrl.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module move_ctrl (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    slot,
	input  logic                    cmd_start,
	input  stepper_pkg::motor_cmd_t cmd,
	input  stepper_pkg::tab_addr_t  tab_top,
	input  logic                    step_done,
	output logic                    rd_en,
	output stepper_pkg::tab_addr_t  rd_addr,
	output logic                    load,
	output logic                    busy,
	output logic                    dir
);
	stepper_pkg::move_state_e state;
	stepper_pkg::step_t       elapsed; // steps already pulsed
	stepper_pkg::step_t       remain;  // steps left, current one included
	stepper_pkg::tab_addr_t   limit;
	stepper_pkg::step_t       index;
	logic [1:0]               load_pipe;
	logic                     accept;

	function automatic stepper_pkg::step_t min_step(
		input stepper_pkg::step_t a,
		input stepper_pkg::step_t b
	);
		return (a < b) ? a : b;
	endfunction

	assign accept = cmd_start && state == stepper_pkg::idle && cmd.steps != '0;

	// up ramp, down ramp, then the cruise limit and the table top
	always_comb begin
		index = min_step(elapsed, remain - 1'b1);
		index = min_step(index, stepper_pkg::step_t'(limit));
		index = min_step(index, stepper_pkg::step_t'(tab_top));
	end

	assign rd_en = slot && state == stepper_pkg::fetch;
	assign rd_addr = rd_en ? stepper_pkg::tab_addr_t'(index) : '0;
	assign load = load_pipe[1]; // table data lands 2 cycles after the slot
	assign busy = state != stepper_pkg::idle;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= stepper_pkg::idle;
			load_pipe <= '0;
			dir <= 1'b0;
		end else begin
			load_pipe <= {load_pipe[0], rd_en};
			case (state)
				stepper_pkg::idle: begin
					if (accept) begin
						state <= stepper_pkg::fetch;
						dir <= cmd.dir;
					end
				end
				stepper_pkg::fetch: begin
					if (slot) begin
						state <= (remain == 1) ? stepper_pkg::last : stepper_pkg::run;
					end
				end
				stepper_pkg::run: begin
					if (step_done) begin
						state <= stepper_pkg::fetch;
					end
				end
				stepper_pkg::last: begin
					if (step_done) begin
						state <= stepper_pkg::idle;
					end
				end
				default: begin
					state <= stepper_pkg::idle;
				end
			endcase
		end
	end

	// step counters
	always_ff @(posedge clk) begin
		if (accept) begin
			elapsed <= '0;
			remain <= cmd.steps;
			limit <= cmd.limit;
		end else if (step_done) begin
			elapsed <= elapsed + 1'b1;
			remain <= remain - 1'b1;
		end
	end

endmodule

//--- hw/pulse_gen.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module pulse_gen (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     slot,
	input  logic                     load,
	input  stepper_pkg::speed_t      rd_data,
	input  logic                     busy,
	input  logic                     dir,
	output logic                     drive,
	output logic                     step_done,
	output stepper_pkg::motor_stat_t stat
);
	stepper_pkg::speed_t period;
	stepper_pkg::speed_t cnt;
	stepper_pkg::step_t  position;
	logic                armed; // a period is loaded and counting
	logic                expire;

	assign expire = slot && armed && cnt == stepper_pkg::speed_t'(1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			drive <= 1'b0;
			position <= '0;
		end else begin
			drive <= expire; // one cycle, right after the slot tick
			if (load) begin
				armed <= 1'b1;
			end else if (expire) begin
				armed <= 1'b0;
			end
			if (drive) begin
				position <= dir ? position + 1'b1 : position - 1'b1;
			end
		end
	end

	// the fetch slot tick of this step has already passed at load
	always_ff @(posedge clk) begin
		if (load) begin
			period <= rd_data;
			cnt <= rd_data - 1'b1;
		end else if (slot && armed) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign step_done = drive;

	assign stat.busy = busy;
	assign stat.rt_speed = busy ? period : '0;
	assign stat.position = position;

endmodule

//--- hw/stepper_top.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module stepper_top (
	input  logic                                           clk,
	input  logic                                           resetn,
	input  logic                                           tab_load,
	input  logic                                           tab_wr,
	input  stepper_pkg::speed_t                            tab_data,
	input  logic [`STEP_MOTOR_NBR-1:0]                     cmd_start,
	input  stepper_pkg::motor_cmd_t [`STEP_MOTOR_NBR-1:0]  cmd,
	output logic [`STEP_MOTOR_NBR-1:0]                     drive,
	output logic [`STEP_MOTOR_NBR-1:0]                     dir,
	output stepper_pkg::motor_stat_t [`STEP_MOTOR_NBR-1:0] stat
);
	logic [`STEP_SLOT_DIV-1:0]                    slot; // one-hot ring
	logic [`STEP_MOTOR_NBR-1:0]                   rd_en;
	stepper_pkg::tab_addr_t [`STEP_MOTOR_NBR-1:0] rd_addr;
	logic [`STEP_MOTOR_NBR-1:0]                   load;
	logic [`STEP_MOTOR_NBR-1:0]                   busy;
	logic [`STEP_MOTOR_NBR-1:0]                   step_done;
	stepper_pkg::speed_t                          rd_data;
	stepper_pkg::tab_addr_t                       tab_top;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			slot <= {{(`STEP_SLOT_DIV-1){1'b0}}, 1'b1};
		end else begin
			slot <= {slot[`STEP_SLOT_DIV-2:0], slot[`STEP_SLOT_DIV-1]};
		end
	end

	speed_table u_table (
		.clk      (clk),
		.resetn   (resetn),
		.tab_load (tab_load),
		.tab_wr   (tab_wr),
		.tab_data (tab_data),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.tab_top  (tab_top)
	);

	for (genvar i = 0; i < `STEP_MOTOR_NBR; i++) begin : g_motor
		move_ctrl u_ctrl (
			.clk       (clk),
			.resetn    (resetn),
			.slot      (slot[i]),
			.cmd_start (cmd_start[i]),
			.cmd       (cmd[i]),
			.tab_top   (tab_top),
			.step_done (step_done[i]),
			.rd_en     (rd_en[i]),
			.rd_addr   (rd_addr[i]),
			.load      (load[i]),
			.busy      (busy[i]),
			.dir       (dir[i])
		);

		pulse_gen u_pulse (
			.clk       (clk),
			.resetn    (resetn),
			.slot      (slot[i]),
			.load      (load[i]),
			.rd_data   (rd_data), // shared, valid for this motor at load
			.busy      (busy[i]),
			.dir       (dir[i]),
			.drive     (drive[i]),
			.step_done (step_done[i]),
			.stat      (stat[i])
		);
	end

endmodule

//--- tests/stepper_chk.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module stepper_chk (
	input logic                                           clk,
	input logic                                           resetn,
	input logic [`STEP_SLOT_DIV-1:0]                      slot,
	input logic [`STEP_MOTOR_NBR-1:0]                     drive,
	input stepper_pkg::motor_stat_t [`STEP_MOTOR_NBR-1:0] stat
);
	for (genvar i = 0; i < `STEP_MOTOR_NBR; i++) begin : g_motor
		a_drive_busy: assert property (@(posedge clk) disable iff (!resetn)
			drive[i] |-> stat[i].busy)
			else $error("motor %0d drive high while idle", i);

		a_drive_single: assert property (@(posedge clk) disable iff (!resetn)
			drive[i] |=> !drive[i])
			else $error("motor %0d drive high two cycles in a row", i);

		// pulse follows own slot tick
		a_drive_slot: assert property (@(posedge clk) disable iff (!resetn)
			$rose(drive[i]) |-> $past(slot[i]))
			else $error("motor %0d drive rose outside its slot", i);

		a_pos_hold: assert property (@(posedge clk) disable iff (!resetn)
			!stat[i].busy && !$past(stat[i].busy) |-> $stable(stat[i].position))
			else $error("motor %0d position moved while idle", i);
	end

endmodule

bind stepper_top stepper_chk u_chk (
	.clk    (clk),
	.resetn (resetn),
	.slot   (slot),
	.drive  (drive),
	.stat   (stat)
);

//--- tests/stepper_tb.sv
`timescale 1ns/10ps
`include "stepper_cfg.svh"

module stepper_tb;
	localparam int NMOT = `STEP_MOTOR_NBR;
	localparam int DIV = `STEP_SLOT_DIV;

	logic                                clk;
	logic                                resetn;
	logic                                tab_load;
	logic                                tab_wr;
	stepper_pkg::speed_t                 tab_data;
	logic [NMOT-1:0]                     cmd_start;
	stepper_pkg::motor_cmd_t [NMOT-1:0]  cmd;
	logic [NMOT-1:0]                     drive;
	logic [NMOT-1:0]                     dir;
	stepper_pkg::motor_stat_t [NMOT-1:0] stat;

	stepper_pkg::speed_t     ref_tab [`STEP_TAB_DEPTH]; // model of the table
	int                      ref_top;
	int                      ref_cnt;
	stepper_pkg::motor_cmd_t exp_cmd [NMOT];
	logic [NMOT-1:0]         active;
	logic [NMOT-1:0]         queued;
	int                      pulse_cnt [NMOT];
	int                      last_pulse [NMOT];
	int                      mot_err [NMOT];
	int                      cyc;
	int                      err_cnt;
	int                      test_cnt;
	int                      fail_cnt;
	logic                    timed_out;

	stepper_top dut (
		.clk       (clk),
		.resetn    (resetn),
		.tab_load  (tab_load),
		.tab_wr    (tab_wr),
		.tab_data  (tab_data),
		.cmd_start (cmd_start),
		.cmd       (cmd),
		.drive     (drive),
		.dir       (dir),
		.stat      (stat)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// step n uses min(n, S-1-n, limit, top)
	function automatic stepper_pkg::speed_t ref_speed(input int m, input int n);
		int idx;
		idx = n;
		if (int'(exp_cmd[m].steps) - 1 - n < idx) idx = int'(exp_cmd[m].steps) - 1 - n;
		if (int'(exp_cmd[m].limit) < idx) idx = int'(exp_cmd[m].limit);
		if (ref_top < idx) idx = ref_top;
		return ref_tab[idx];
	endfunction

	function automatic int move_cycles(input int m);
		int sum;
		sum = 4 * DIV;
		for (int n = 0; n < int'(exp_cmd[m].steps); n++) sum += int'(ref_speed(m, n)) * DIV;
		return sum;
	endfunction

	task automatic check_speed(input int m, input string what,
			input stepper_pkg::speed_t got, input stepper_pkg::speed_t want);
		if (got !== want) begin
			$display("error at %0t: motor %0d %s is %0d, expected %0d", $time, m, what, got, want);
			err_cnt++;
			mot_err[m]++;
		end
	endtask

	task automatic check_step(input int m, input string what,
			input stepper_pkg::step_t got, input stepper_pkg::step_t want);
		if (got !== want) begin
			$display("error at %0t: motor %0d %s is %0d, expected %0d", $time, m, what, got, want);
			err_cnt++;
			mot_err[m]++;
		end
	endtask

	task automatic check_bit(input int m, input string what, input logic got, input logic want);
		if (got !== want) begin
			$display("error at %0t: motor %0d %s is %b, expected %b", $time, m, what, got, want);
			err_cnt++;
			mot_err[m]++;
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#5;
	endtask

	// pulse monitor, mid-cycle
	always @(negedge clk) begin
		cyc = cyc + 1;
		for (int m = 0; m < NMOT; m++) begin
			// busy stays up until the cycle after the final pulse
			if (resetn && active[m] && pulse_cnt[m] > 0) begin
				check_bit(m, "busy", stat[m].busy, pulse_cnt[m] < int'(exp_cmd[m].steps));
			end
			if (resetn && drive[m]) begin
				if (!active[m] || pulse_cnt[m] >= int'(exp_cmd[m].steps)) begin
					$display("motor %0d gave a pulse that no move asked for", m);
					err_cnt++;
					mot_err[m]++;
				end else begin
					check_bit(m, "busy at pulse", stat[m].busy, 1'b1);
					check_bit(m, "dir at pulse", dir[m], exp_cmd[m].dir);
					check_speed(m, "rt_speed", stat[m].rt_speed, ref_speed(m, pulse_cnt[m]));
					if (pulse_cnt[m] > 0) begin
						check_step(m, "pulse interval", stepper_pkg::step_t'(cyc - last_pulse[m]),
							stepper_pkg::step_t'(int'(ref_speed(m, pulse_cnt[m])) * DIV));
					end
				end
				last_pulse[m] = cyc;
				pulse_cnt[m] = pulse_cnt[m] + 1;
			end
		end
	end

	task automatic write_entry(input stepper_pkg::speed_t v);
		tab_wr = 1'b1;
		tab_data = v;
		tick();
		tab_wr = 1'b0;
		ref_tab[ref_cnt] = v;
		ref_top = ref_cnt; // last written address is the top
		ref_cnt++;
	endtask

	task automatic wait_moves(input int start_cyc);
		int limit;
		for (int m = 0; m < NMOT; m++) begin
			if (queued[m] && exp_cmd[m].steps != '0) begin
				limit = (3 + int'(ref_speed(m, 0))) * DIV + 2;
				while (!timed_out && pulse_cnt[m] == 0) begin
					if (cyc - start_cyc > limit) begin
						$display("timeout: motor %0d gave no first pulse in %0d cycles", m, limit);
						timed_out = 1'b1;
					end else begin
						tick();
					end
				end
			end
		end
		for (int m = 0; m < NMOT; m++) begin
			limit = move_cycles(m);
			while (!timed_out && queued[m] && stat[m].busy) begin
				if (cyc - start_cyc > limit) begin
					$display("timeout: motor %0d still busy after %0d cycles", m, limit);
					timed_out = 1'b1;
				end else begin
					tick();
				end
			end
		end
	endtask

	task automatic run_moves();
		stepper_pkg::step_t start_pos [NMOT];
		stepper_pkg::step_t want_pos;
		int                 start_cyc;
		for (int m = 0; m < NMOT; m++) begin
			start_pos[m] = stat[m].position;
			pulse_cnt[m] = 0;
			mot_err[m] = 0;
			if (queued[m]) cmd[m] = exp_cmd[m];
		end
		active = queued;
		cmd_start = queued; // all motors in one cycle
		tick();
		start_cyc = cyc;
		cmd_start = '0;
		for (int m = 0; m < NMOT; m++) begin
			if (queued[m]) begin
				check_bit(m, "busy after start", stat[m].busy, exp_cmd[m].steps != '0);
				if (exp_cmd[m].steps != '0) begin
					cmd[m].steps = exp_cmd[m].steps + 16'd5; // must be ignored
					cmd[m].dir = ~exp_cmd[m].dir;
					cmd_start[m] = 1'b1;
				end
			end
		end
		tick();
		cmd_start = '0;
		wait_moves(start_cyc);
		tick(); // monitor sees the cycle where busy fell
		for (int m = 0; m < NMOT; m++) begin
			if (queued[m]) begin
				want_pos = exp_cmd[m].dir ? start_pos[m] + exp_cmd[m].steps
					: start_pos[m] - exp_cmd[m].steps;
				check_step(m, "pulse count", stepper_pkg::step_t'(pulse_cnt[m]), exp_cmd[m].steps);
				check_step(m, "position", stat[m].position, want_pos);
				check_speed(m, "idle rt_speed", stat[m].rt_speed, '0);
				if (exp_cmd[m].steps != '0) check_bit(m, "dir after move", dir[m], exp_cmd[m].dir);
				test_cnt++;
				if (mot_err[m] != 0) fail_cnt++;
				$display("test %0d motor %0d: %0d steps, limit %0d, dir %0d, %0d errors", test_cnt,
					m, exp_cmd[m].steps, exp_cmd[m].limit, exp_cmd[m].dir, mot_err[m]);
			end
		end
		queued = '0;
		active = '0;
	endtask

	task automatic run_trace(input int fd);
		string line;
		byte   op;
		int    v;
		int    m;
		int    s;
		int    l;
		int    d;
		logic  loading;
		loading = 1'b0;
		while (!timed_out && $fgets(line, fd) != 0) begin
			op = (line.len() > 0) ? line[0] : 8'h00;
			if (loading && op != "w") begin
				tab_load = 1'b0; // closes the load window
				tick();
				loading = 1'b0;
			end
			if (op == "w" && $sscanf(line, "w %d", v) == 1) begin
				if (!loading) begin
					tab_load = 1'b1;
					ref_cnt = 0;
					loading = 1'b1;
				end
				write_entry(stepper_pkg::speed_t'(v));
			end else if (op == "m" && $sscanf(line, "m %d %d %d %d", m, s, l, d) == 4 && m < NMOT) begin
				exp_cmd[m].steps = stepper_pkg::step_t'(s);
				exp_cmd[m].limit = stepper_pkg::tab_addr_t'(l);
				exp_cmd[m].dir = d[0];
				queued[m] = 1'b1;
			end else if (op == "g") begin
				run_moves();
				repeat ($urandom % 16) tick(); // idle gap
			end else if (op != "#" && line.len() > 1) begin
				$display("trace line could not be read: %s", line);
				err_cnt++;
			end
		end
		tab_load = 1'b0;
	endtask

	initial begin
		int fd;
		void'($urandom(57144));
		resetn = 1'b0;
		tab_load = 1'b0;
		tab_wr = 1'b0;
		tab_data = '0;
		cmd_start = '0;
		cmd = '0;
		active = '0;
		queued = '0;
		cyc = 0;
		err_cnt = 0;
		test_cnt = 0;
		fail_cnt = 0;
		timed_out = 1'b0;
		ref_top = 0;
		ref_cnt = 0;
		for (int m = 0; m < NMOT; m++) begin
			pulse_cnt[m] = 0;
			last_pulse[m] = 0;
			mot_err[m] = 0;
			exp_cmd[m] = '0;
		end
		repeat (8) @(posedge clk);
		#5;
		resetn = 1'b1;
		tick();
		fd = $fopen("tests/stepper_trace.txt", "r");
		if (fd == 0) begin
			$display("trace file tests/stepper_trace.txt could not be opened");
			err_cnt++;
		end else begin
			run_trace(fd);
			$fclose(fd);
		end
		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0 && !timed_out && test_cnt > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- tests/stepper_trace.txt
# w <period>: table entry at the next address, a run of w lines is one load
# m <motor> <steps> <limit> <dir>: queue a move, g: start queued moves and check them
w 40
w 30
w 22
w 16
w 12
w 9
w 7
w 5
m 0 20 5 1
g
m 1 7 6 0
g
m 2 30 100 1
g
m 0 15 3 0
m 1 9 8 1
m 2 24 7 0
m 3 1 0 1
g
w 20
w 10
w 4
m 3 12 50 0
m 1 0 3 1
g

//--- src.f
+incdir+hw
hw/stepper_pkg.sv
hw/speed_table.sv
hw/move_ctrl.sv
hw/pulse_gen.sv
hw/stepper_top.sv
tests/stepper_chk.sv
tests/stepper_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stepper_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
